/* msr_pkg.sv */
/* MSR subsystem definitions
   Widths, address map, PSR layout and the write-request structs
   shared by the execution unit, the state bank and the IMMU TLB */
package msr_pkg;

   localparam int MSR_DW      = 32;
   localparam int PSR_DW      = 10;
   localparam int BANK_AW     = 4;
   localparam int BANK_OFF_AW = 9;

   typedef logic [MSR_DW-1:0]      msr_data_t;
   typedef logic [BANK_AW-1:0]     bank_addr_t;
   typedef logic [BANK_OFF_AW-1:0] bank_off_t;

   // Processor status word, cc sits in bit 0
   typedef struct packed {
      logic res9;
      logic res8;
      logic dmme;
      logic imme;
      logic ire;
      logic rm;
      logic res3;
      logic res2;
      logic res1;
      logic cc;
   } psr_t;

   // Bank numbers
   localparam bank_addr_t MSR_BANK_PS  = 4'd0;
   localparam bank_addr_t MSR_BANK_IMM = 4'd1;

   // One-hot offset bits in the processor-state bank
   localparam int MSR_PSR    = 0;
   localparam int MSR_CPUID  = 1;
   localparam int MSR_EPSR   = 2;
   localparam int MSR_EPC    = 3;
   localparam int MSR_ELSA   = 4;
   localparam int MSR_COREID = 5;

   // IMMU offset bits, the low bits carry the TLB index
   localparam int MSR_IMM_TLBSEL   = 8;
   localparam int MSR_IMM_TLBH_SEL = 7;

   localparam msr_data_t CPUID_VALUE = 32'h4e43_0100;
   localparam msr_data_t IMMID_VALUE = 32'h0005_0001;

   // Supervisor mode out of reset
   localparam psr_t PSR_RESET = '{rm: 1'b1, default: 1'b0};

   typedef struct packed {
      logic rmsr;
      logic wmsr;
   } eu_op_t;

   typedef struct packed {
      logic cc_nxt;
      logic cc_we;
      logic rm_nxt;
      logic rm_we;
      logic ire_nxt;
      logic ire_we;
      logic imme_nxt;
      logic imme_we;
      logic dmme_nxt;
      logic dmme_we;
      logic syscall_ent;
   } psr_upd_t;

   typedef struct packed {
      msr_data_t epc_nxt;
      logic      epc_we;
      psr_t      epsr_nxt;
      logic      epsr_we;
      msr_data_t elsa_nxt;
      logic      elsa_we;
   } exc_wr_t;

endpackage

/* imm_tlb.sv */
/* Instruction MMU TLB
   Low and high word arrays, synchronous write and combinational read */
`timescale 1ns/1ns

module imm_tlb #(
   parameter int TLB_AW = 5
) (
   input  logic               clk,
   input  logic               tlbl_we,
   input  logic               tlbh_we,
   input  logic [TLB_AW-1:0]  tlb_idx,
   input  msr_pkg::msr_data_t tlb_wdata,
   output msr_pkg::msr_data_t tlbl_rdata,
   output msr_pkg::msr_data_t tlbh_rdata
);
   import msr_pkg::*;

   localparam int TLB_DEPTH = 2 ** TLB_AW;

   msr_data_t tlbl_mem [TLB_DEPTH];
   msr_data_t tlbh_mem [TLB_DEPTH];

   always_ff @(posedge clk) begin
      if (tlbl_we)
         tlbl_mem[tlb_idx] <= tlb_wdata;
   end

   always_ff @(posedge clk) begin
      if (tlbh_we)
         tlbh_mem[tlb_idx] <= tlb_wdata;
   end

   // Both words share one index
   assign tlbl_rdata = tlbl_mem[tlb_idx];
   assign tlbh_rdata = tlbh_mem[tlb_idx];

   a_tlb_we_mutex : assert property (@(posedge clk)
      tlbl_we |-> !tlbh_we)
      else $error("imm_tlb: low and high words written together");

endmodule

/* ps_bank.sv */
/* Processor-state bank
   Holds PSR, EPSR, EPC and ELSA and reads back CPUID and COREID */
`timescale 1ns/1ns

module ps_bank #(
   parameter msr_pkg::msr_data_t CORE_ID = 32'h0000_0000
) (
   input  logic               clk,
   input  logic               rst_n,
   input  msr_pkg::bank_off_t ps_off,
   input  msr_pkg::psr_upd_t  psr_upd,
   input  msr_pkg::exc_wr_t   exc_wr,
   output msr_pkg::msr_data_t ps_dout,
   output msr_pkg::psr_t      psr,
   output msr_pkg::psr_t      epsr
);
   import msr_pkg::*;

   psr_t      psr_q;
   psr_t      epsr_q;
   msr_data_t epc_q;
   msr_data_t elsa_q;
   logic      syscall_take;

   // EPSR enable already carries commit
   assign syscall_take = psr_upd.syscall_ent & exc_wr.epsr_we;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         psr_q <= PSR_RESET;
      end else begin
         if (psr_upd.cc_we)
            psr_q.cc <= psr_upd.cc_nxt;
         if (psr_upd.rm_we)
            psr_q.rm <= psr_upd.rm_nxt;
         if (psr_upd.ire_we)
            psr_q.ire <= psr_upd.ire_nxt;
         if (psr_upd.imme_we)
            psr_q.imme <= psr_upd.imme_nxt;
         if (psr_upd.dmme_we)
            psr_q.dmme <= psr_upd.dmme_nxt;
         // Enter supervisor mode with interrupts masked
         if (syscall_take) begin
            psr_q.rm  <= 1'b1;
            psr_q.ire <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         epsr_q <= '0;
         epc_q  <= '0;
         elsa_q <= '0;
      end else begin
         if (exc_wr.epsr_we)
            epsr_q <= exc_wr.epsr_nxt;
         if (exc_wr.epc_we)
            epc_q <= exc_wr.epc_nxt;
         if (exc_wr.elsa_we)
            elsa_q <= exc_wr.elsa_nxt;
      end
   end

   assign psr  = psr_q;
   assign epsr = epsr_q;

   assign ps_dout = ({MSR_DW{ps_off[MSR_PSR]}}    & {{(MSR_DW-PSR_DW){1'b0}}, psr_q}) |
                    ({MSR_DW{ps_off[MSR_CPUID]}}  & CPUID_VALUE) |
                    ({MSR_DW{ps_off[MSR_EPSR]}}   & {{(MSR_DW-PSR_DW){1'b0}}, epsr_q}) |
                    ({MSR_DW{ps_off[MSR_EPC]}}    & epc_q) |
                    ({MSR_DW{ps_off[MSR_ELSA]}}   & elsa_q) |
                    ({MSR_DW{ps_off[MSR_COREID]}} & CORE_ID);

   a_syscall_no_field_wr : assert property (@(posedge clk) disable iff (!rst_n)
      syscall_take |-> !(psr_upd.cc_we | psr_upd.rm_we | psr_upd.ire_we |
                         psr_upd.imme_we | psr_upd.dmme_we))
      else $error("ps_bank: syscall entry together with a PSR field write");

endmodule

/* msr_eu.sv */
/* MSR execution unit
   Decodes the MSR address, selects read data and forms the write
   requests for the processor-state bank and the IMMU TLB */
`timescale 1ns/1ns

module msr_eu #(
   parameter int TLB_AW = 5
) (
   input  logic               clk,
   input  logic               rst_n,
   input  msr_pkg::eu_op_t    op,
   input  msr_pkg::msr_data_t operand_1,
   input  msr_pkg::msr_data_t operand_2,
   input  msr_pkg::msr_data_t operand_3,
   input  logic               commit,
   input  logic               au_cc_we,
   input  logic               au_cc_nxt,
   input  logic               ret,
   input  logic               syscall,
   input  msr_pkg::msr_data_t linkaddr,
   input  msr_pkg::psr_t      psr,
   input  msr_pkg::psr_t      epsr,
   input  msr_pkg::msr_data_t ps_dout,
   input  msr_pkg::msr_data_t tlbl_rdata,
   input  msr_pkg::msr_data_t tlbh_rdata,
   output logic               dout_op,
   output msr_pkg::msr_data_t dout,
   output msr_pkg::psr_upd_t  psr_upd,
   output msr_pkg::exc_wr_t   exc_wr,
   output msr_pkg::bank_off_t ps_off,
   output logic               tlbl_we,
   output logic               tlbh_we,
   output logic [TLB_AW-1:0]  tlb_idx,
   output msr_pkg::msr_data_t tlb_wdata
);
   import msr_pkg::*;

   msr_data_t  msr_addr;
   bank_addr_t bank_addr;
   bank_off_t  bank_off;
   logic       bank_ps;
   logic       bank_imm;
   logic       tlbl_sel;
   logic       tlbh_sel;
   msr_data_t  dout_imm;
   logic       wmsr_psr_we;
   logic       wmsr_epsr_we;
   logic       wmsr_epc_we;
   logic       wmsr_elsa_we;
   psr_t       wmsr_psr;

   // Address is operand 1 plus operand 2
   assign msr_addr  = operand_1 + operand_2;
   assign bank_addr = msr_addr[BANK_OFF_AW +: BANK_AW];
   assign bank_off  = msr_addr[BANK_OFF_AW-1:0];
   assign bank_ps   = (bank_addr == MSR_BANK_PS);
   assign bank_imm  = (bank_addr == MSR_BANK_IMM);
   assign ps_off    = bank_off;

   // IMMU readout
   assign tlbl_sel = bank_off[MSR_IMM_TLBSEL] & ~bank_off[MSR_IMM_TLBH_SEL];
   assign tlbh_sel = bank_off[MSR_IMM_TLBSEL] & bank_off[MSR_IMM_TLBH_SEL];
   assign dout_imm = ({MSR_DW{~bank_off[MSR_IMM_TLBSEL]}} & IMMID_VALUE) |
                     ({MSR_DW{tlbl_sel}} & tlbl_rdata) |
                     ({MSR_DW{tlbh_sel}} & tlbh_rdata);

   // Unimplemented banks read as zero
   assign dout    = ({MSR_DW{bank_ps}} & ps_dout) | ({MSR_DW{bank_imm}} & dout_imm);
   assign dout_op = op.rmsr;

   assign wmsr_psr_we  = op.wmsr & bank_ps & bank_off[MSR_PSR];
   assign wmsr_epsr_we = op.wmsr & bank_ps & bank_off[MSR_EPSR];
   assign wmsr_epc_we  = op.wmsr & bank_ps & bank_off[MSR_EPC];
   assign wmsr_elsa_we = op.wmsr & bank_ps & bank_off[MSR_ELSA];
   assign wmsr_psr     = psr_t'(operand_3[PSR_DW-1:0]);

   // PSR fields come from a WMSR or, on return, from EPSR
   always_comb begin
      psr_upd.cc_nxt      = au_cc_we ? au_cc_nxt :
                            wmsr_psr_we ? wmsr_psr.cc : epsr.cc;
      psr_upd.cc_we       = commit & (ret | au_cc_we | wmsr_psr_we);
      psr_upd.rm_nxt      = wmsr_psr_we ? wmsr_psr.rm : epsr.rm;
      psr_upd.rm_we       = commit & (ret | wmsr_psr_we);
      psr_upd.ire_nxt     = wmsr_psr_we ? wmsr_psr.ire : epsr.ire;
      psr_upd.ire_we      = commit & (ret | wmsr_psr_we);
      psr_upd.imme_nxt    = wmsr_psr_we ? wmsr_psr.imme : epsr.imme;
      psr_upd.imme_we     = commit & (ret | wmsr_psr_we);
      psr_upd.dmme_nxt    = wmsr_psr_we ? wmsr_psr.dmme : epsr.dmme;
      psr_upd.dmme_we     = commit & (ret | wmsr_psr_we);
      psr_upd.syscall_ent = syscall;
   end

   // Syscall saves the current PSR and the link address
   always_comb begin
      exc_wr.epsr_nxt = wmsr_epsr_we ? wmsr_psr : psr;
      exc_wr.epsr_we  = commit & (syscall | wmsr_epsr_we);
      exc_wr.epc_nxt  = wmsr_epc_we ? operand_3 : linkaddr;
      exc_wr.epc_we   = commit & (syscall | wmsr_epc_we);
      exc_wr.elsa_nxt = operand_3;
      exc_wr.elsa_we  = wmsr_elsa_we;
   end

   // TLB writes are not gated by commit
   assign tlb_idx   = bank_off[TLB_AW-1:0];
   assign tlb_wdata = operand_3;
   assign tlbl_we   = op.wmsr & bank_imm & tlbl_sel;
   assign tlbh_we   = op.wmsr & bank_imm & tlbh_sel;

   // Only one committed source may drive the PSR in a cycle
   a_psr_src_mutex : assert property (@(posedge clk) disable iff (!rst_n)
      commit |-> $onehot0({ret, syscall, au_cc_we, wmsr_psr_we}))
      else $error("msr_eu: committed PSR sources are not mutually exclusive");

   a_op_mutex : assert property (@(posedge clk) disable iff (!rst_n)
      !(op.rmsr && op.wmsr))
      else $error("msr_eu: rmsr and wmsr set together");

endmodule

/* msr_unit.sv */
/* MSR subsystem top level
   Connects the execution unit, the processor-state bank and the IMMU TLB */
`timescale 1ns/1ns

module msr_unit #(
   parameter int                 TLB_AW  = 5,
   parameter msr_pkg::msr_data_t CORE_ID = 32'h0000_0000
) (
   input  logic               clk,
   input  logic               rst_n,
   input  msr_pkg::eu_op_t    op,
   input  msr_pkg::msr_data_t operand_1,
   input  msr_pkg::msr_data_t operand_2,
   input  msr_pkg::msr_data_t operand_3,
   input  logic               commit,
   input  logic               au_cc_we,
   input  logic               au_cc_nxt,
   input  logic               ret,
   input  logic               syscall,
   input  msr_pkg::msr_data_t linkaddr,
   output msr_pkg::msr_data_t dout,
   output logic               dout_op,
   output msr_pkg::psr_t      psr
);
   import msr_pkg::*;

   psr_upd_t            psr_upd;
   exc_wr_t             exc_wr;
   bank_off_t           ps_off;
   msr_data_t           ps_dout;
   psr_t                epsr;
   logic                tlbl_we;
   logic                tlbh_we;
   logic [TLB_AW-1:0]   tlb_idx;
   msr_data_t           tlb_wdata;
   msr_data_t           tlbl_rdata;
   msr_data_t           tlbh_rdata;

   msr_eu #(.TLB_AW(TLB_AW)) i_msr_eu (
      .clk, .rst_n, .op, .operand_1, .operand_2, .operand_3,
      .commit, .au_cc_we, .au_cc_nxt, .ret, .syscall, .linkaddr,
      .psr, .epsr, .ps_dout, .tlbl_rdata, .tlbh_rdata,
      .dout_op, .dout, .psr_upd, .exc_wr, .ps_off,
      .tlbl_we, .tlbh_we, .tlb_idx, .tlb_wdata
   );

   ps_bank #(.CORE_ID(CORE_ID)) i_ps_bank (
      .clk, .rst_n, .ps_off, .psr_upd, .exc_wr,
      .ps_dout, .psr, .epsr
   );

   imm_tlb #(.TLB_AW(TLB_AW)) i_imm_tlb (
      .clk, .tlbl_we, .tlbh_we, .tlb_idx, .tlb_wdata,
      .tlbl_rdata, .tlbh_rdata
   );

endmodule

/* tb_msr_unit.sv */
/* Testbench for the MSR subsystem
   Directed tests of the state bank, the syscall and return flow and the IMMU TLB */
`timescale 1ns/1ns

module tb_msr_unit;
   import msr_pkg::*;

   localparam int        CLK_PERIOD  = 8;
   localparam int        TLB_AW      = 5;
   localparam int        TLB_DEPTH   = 2 ** TLB_AW;
   localparam int        TLB_WRITES  = 12;
   localparam msr_data_t TB_CORE_ID  = 32'h0000_0c07;
   // Reset, reset values, writes, cc, syscall, TLB, unused banks
   localparam int        TEST_CYCLES = 3 + 6 + 17 + 3 + 8 + (3 * TLB_WRITES + 2) + 6;
   localparam int        WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

   logic        clk;
   logic        rst_n;
   eu_op_t      op;
   msr_data_t   operand_1;
   msr_data_t   operand_2;
   msr_data_t   operand_3;
   logic        commit;
   logic        au_cc_we;
   logic        au_cc_nxt;
   logic        ret;
   logic        syscall;
   msr_data_t   linkaddr;
   msr_data_t   dout;
   logic        dout_op;
   psr_t        psr;

   logic [15:0] lfsr_state;
   psr_t        psr_model;
   psr_t        epsr_model;
   msr_data_t   epc_model;
   msr_data_t   elsa_model;
   msr_data_t   tlbl_model [TLB_DEPTH];
   msr_data_t   tlbh_model [TLB_DEPTH];
   bit          tlbl_valid [TLB_DEPTH];
   bit          tlbh_valid [TLB_DEPTH];

   msr_unit #(.TLB_AW(TLB_AW), .CORE_ID(TB_CORE_ID)) i_msr_unit (
      .clk(clk), .rst_n(rst_n), .op(op),
      .operand_1(operand_1), .operand_2(operand_2), .operand_3(operand_3),
      .commit(commit), .au_cc_we(au_cc_we), .au_cc_nxt(au_cc_nxt),
      .ret(ret), .syscall(syscall), .linkaddr(linkaddr),
      .dout(dout), .dout_op(dout_op), .psr(psr)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // 16-bit Galois LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] state);
      lfsr_next = state >> 1;
      if (state[0])
         lfsr_next = lfsr_next ^ 16'hb400;
   endfunction

   function automatic msr_data_t rand_bits(input int n);
      msr_data_t bits;
      int        i;
      bits = '0;
      for (i = 0; i < n; i++) begin
         bits       = {bits[MSR_DW-2:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return bits;
   endfunction

   function automatic bank_off_t ps_sel(input int bit_pos);
      ps_sel         = '0;
      ps_sel[bit_pos] = 1'b1;
   endfunction

   function automatic bank_off_t tlb_off(input logic [TLB_AW-1:0] idx, input logic hi);
      tlb_off                   = '0;
      tlb_off[MSR_IMM_TLBSEL]   = 1'b1;
      tlb_off[MSR_IMM_TLBH_SEL] = hi;
      tlb_off[TLB_AW-1:0]       = idx;
   endfunction

   function automatic msr_data_t psr_word(input psr_t p);
      return {{(MSR_DW-PSR_DW){1'b0}}, p};
   endfunction

   task automatic check_data(input msr_data_t got, input msr_data_t exp, input string what);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
         $display("TB FAILED");
         $fatal(1, "data compare failed");
      end
   endtask

   task automatic check_psr(input psr_t got, input psr_t exp, input string what);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
         $display("TB FAILED");
         $fatal(1, "psr compare failed");
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
         $display("TB FAILED");
         $fatal(1, "flag compare failed");
      end
   endtask

   task automatic set_idle();
      op        = '0;
      operand_1 = '0;
      operand_2 = '0;
      operand_3 = '0;
      commit    = 1'b0;
      au_cc_we  = 1'b0;
      au_cc_nxt = 1'b0;
      ret       = 1'b0;
      syscall   = 1'b0;
      linkaddr  = '0;
   endtask

   task automatic idle_cycle();
      @(negedge clk);
      set_idle();
      #1;
   endtask

   // Random split of the address over both operands
   task automatic drive_addr(input bank_addr_t bank, input bank_off_t off);
      msr_data_t addr;
      addr      = {19'd0, bank, off};
      operand_1 = rand_bits(MSR_DW);
      operand_2 = addr - operand_1;
   endtask

   task automatic read_reg(input bank_addr_t bank, input bank_off_t off,
                           input msr_data_t exp, input string what);
      @(negedge clk);
      set_idle();
      op.rmsr = 1'b1;
      drive_addr(bank, off);
      #1;
      check_data(dout, exp, what);
      check_flag(dout_op, 1'b1, "dout_op during a read");
   endtask

   task automatic write_reg(input bank_addr_t bank, input bank_off_t off,
                            input msr_data_t data, input logic cmt);
      @(negedge clk);
      set_idle();
      op.wmsr   = 1'b1;
      operand_3 = data;
      commit    = cmt;
      drive_addr(bank, off);
   endtask

   task automatic test_reset_values();
      psr_model  = PSR_RESET;
      epsr_model = '0;
      epc_model  = '0;
      elsa_model = '0;
      check_psr(psr, PSR_RESET, "psr after reset");
      read_reg(MSR_BANK_PS, ps_sel(MSR_PSR), psr_word(PSR_RESET), "PSR after reset");
      read_reg(MSR_BANK_PS, ps_sel(MSR_CPUID), CPUID_VALUE, "CPUID");
      read_reg(MSR_BANK_PS, ps_sel(MSR_COREID), TB_CORE_ID, "COREID");
      read_reg(MSR_BANK_PS, ps_sel(MSR_EPSR), '0, "EPSR after reset");
      read_reg(MSR_BANK_PS, ps_sel(MSR_EPC), '0, "EPC after reset");
      read_reg(MSR_BANK_PS, ps_sel(MSR_ELSA), '0, "ELSA after reset");
   endtask

   task automatic test_write_commit();
      msr_data_t psr_val;
      msr_data_t epsr_val;
      msr_data_t epc_val;
      msr_data_t elsa_val;
      // User mode with dmme, imme, ire and cc set
      psr_val  = 32'h0000_00e1;
      epsr_val = 32'h0000_00d1;
      epc_val  = rand_bits(MSR_DW);
      elsa_val = rand_bits(MSR_DW);
      write_reg(MSR_BANK_PS, ps_sel(MSR_PSR), psr_val, 1'b1);
      write_reg(MSR_BANK_PS, ps_sel(MSR_EPSR), epsr_val, 1'b1);
      write_reg(MSR_BANK_PS, ps_sel(MSR_EPC), epc_val, 1'b1);
      write_reg(MSR_BANK_PS, ps_sel(MSR_ELSA), elsa_val, 1'b1);
      psr_model  = psr_t'(psr_val[PSR_DW-1:0]);
      epsr_model = psr_t'(epsr_val[PSR_DW-1:0]);
      epc_model  = epc_val;
      elsa_model = elsa_val;
      idle_cycle();
      check_psr(psr, psr_model, "psr after committed write");
      read_reg(MSR_BANK_PS, ps_sel(MSR_PSR), psr_word(psr_model), "PSR readback");
      read_reg(MSR_BANK_PS, ps_sel(MSR_EPSR), psr_word(epsr_model), "EPSR readback");
      read_reg(MSR_BANK_PS, ps_sel(MSR_EPC), epc_model, "EPC readback");
      read_reg(MSR_BANK_PS, ps_sel(MSR_ELSA), elsa_model, "ELSA readback");
      // Without commit only ELSA takes the write
      write_reg(MSR_BANK_PS, ps_sel(MSR_PSR), 32'h0000_0010, 1'b0);
      write_reg(MSR_BANK_PS, ps_sel(MSR_EPSR), 32'h0000_0030, 1'b0);
      write_reg(MSR_BANK_PS, ps_sel(MSR_EPC), ~epc_val, 1'b0);
      write_reg(MSR_BANK_PS, ps_sel(MSR_ELSA), ~elsa_val, 1'b0);
      elsa_model = ~elsa_val;
      idle_cycle();
      check_psr(psr, psr_model, "psr after uncommitted write");
      read_reg(MSR_BANK_PS, ps_sel(MSR_EPSR), psr_word(epsr_model), "EPSR uncommitted");
      read_reg(MSR_BANK_PS, ps_sel(MSR_EPC), epc_model, "EPC uncommitted");
      read_reg(MSR_BANK_PS, ps_sel(MSR_ELSA), elsa_model, "ELSA uncommitted");
   endtask

   task automatic test_cc_flag();
      @(negedge clk);
      set_idle();
      commit       = 1'b1;
      au_cc_we     = 1'b1;
      au_cc_nxt    = ~psr_model.cc;
      psr_model.cc = ~psr_model.cc;
      idle_cycle();
      check_psr(psr, psr_model, "psr after condition flag update");
   endtask

   task automatic test_syscall_ret();
      msr_data_t link;
      link = rand_bits(MSR_DW);
      @(negedge clk);
      set_idle();
      commit     = 1'b1;
      syscall    = 1'b1;
      linkaddr   = link;
      epsr_model = psr_model;
      epc_model  = link;
      psr_model.rm  = 1'b1;
      psr_model.ire = 1'b0;
      idle_cycle();
      check_psr(psr, psr_model, "psr after syscall");
      read_reg(MSR_BANK_PS, ps_sel(MSR_EPSR), psr_word(epsr_model), "EPSR after syscall");
      read_reg(MSR_BANK_PS, ps_sel(MSR_EPC), epc_model, "EPC after syscall");
      // Move every restored field away from EPSR before the return
      psr_model.cc   = ~epsr_model.cc;
      psr_model.rm   = ~epsr_model.rm;
      psr_model.ire  = ~epsr_model.ire;
      psr_model.imme = ~epsr_model.imme;
      psr_model.dmme = ~epsr_model.dmme;
      write_reg(MSR_BANK_PS, ps_sel(MSR_PSR), psr_word(psr_model), 1'b1);
      idle_cycle();
      check_psr(psr, psr_model, "psr before return");
      @(negedge clk);
      set_idle();
      commit = 1'b1;
      ret    = 1'b1;
      psr_model.cc   = epsr_model.cc;
      psr_model.rm   = epsr_model.rm;
      psr_model.ire  = epsr_model.ire;
      psr_model.imme = epsr_model.imme;
      psr_model.dmme = epsr_model.dmme;
      idle_cycle();
      check_psr(psr, psr_model, "psr after return");
   endtask

   task automatic test_tlb();
      msr_data_t         r;
      msr_data_t         data;
      logic [TLB_AW-1:0] idx;
      logic              hi;
      int                n;
      for (n = 0; n < TLB_WRITES; n++) begin
         r    = rand_bits(TLB_AW);
         idx  = r[TLB_AW-1:0];
         r    = rand_bits(1);
         hi   = r[0];
         data = rand_bits(MSR_DW);
         write_reg(MSR_BANK_IMM, tlb_off(idx, hi), data, 1'b0);
         if (hi) begin
            tlbh_model[idx] = data;
            tlbh_valid[idx] = 1'b1;
         end else begin
            tlbl_model[idx] = data;
            tlbl_valid[idx] = 1'b1;
         end
      end
      for (n = 0; n < TLB_DEPTH; n++) begin
         if (tlbl_valid[n])
            read_reg(MSR_BANK_IMM, tlb_off(n, 1'b0), tlbl_model[n], "TLB low word");
         if (tlbh_valid[n])
            read_reg(MSR_BANK_IMM, tlb_off(n, 1'b1), tlbh_model[n], "TLB high word");
      end
      r = rand_bits(8);
      read_reg(MSR_BANK_IMM, {1'b0, r[7:0]}, IMMID_VALUE, "IMMID");
   endtask

   task automatic test_unused_banks();
      msr_data_t r;
      int        n;
      for (n = 0; n < 4; n++) begin
         r = rand_bits(BANK_OFF_AW);
         read_reg(bank_addr_t'(2 + 3 * n), r[BANK_OFF_AW-1:0], '0, "unused bank");
      end
      @(negedge clk);
      set_idle();
      drive_addr(MSR_BANK_PS, ps_sel(MSR_CPUID));
      #1;
      check_flag(dout_op, 1'b0, "dout_op without rmsr");
   endtask

   initial begin
      int i;
      lfsr_state = 16'd76;
      rst_n      = 1'b0;
      set_idle();
      for (i = 0; i < TLB_DEPTH; i++) begin
         tlbl_valid[i] = 1'b0;
         tlbh_valid[i] = 1'b0;
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      #1;
      test_reset_values();
      test_write_commit();
      test_cc_flag();
      test_syscall_ret();
      test_tlb();
      test_unused_banks();
      $display("TB PASSED");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired at %0t ns before the tests completed", $time);
      $display("TB FAILED");
      $fatal(1, "simulation timeout");
   end

endmodule

/* verilog.f */
msr_pkg.sv
imm_tlb.sv
ps_bank.sv
msr_eu.sv
msr_unit.sv
tb_msr_unit.sv
